//--- common/fifo_rd_if.sv
/*
 * Read side of the registered FIFO. Data returns one cycle after pop.
 * The FIFO drives status and data, the bridge drives pop, and the
 * control block watches the level.
 */

interface fifo_rd_if
        import stream_pkg::*;
();

        // FIFO holds at least one beat
        logic               avail;
        // Read request, only legal while avail is high
        logic               pop;
        // Beat popped in the previous cycle, held until the next pop
        beat_t              data;
        // Number of beats stored in the FIFO
        logic [LEVEL_W-1:0] level;

        modport fifo (
                output avail,
                output data,
                output level,
                input  pop
        );

        modport bridge (
                input  avail,
                input  data,
                output pop
        );

        // Monitor side, level only
        modport mon (
                input  level
        );

endinterface : fifo_rd_if

//--- common/stream_pkg.sv
/*
 * Shared widths, depths and the beat type for the stream staging channel.
 * Imported by wildcard in the header of every module that needs them.
 */

package stream_pkg;

        // ========================================================================
        // Widths and depths
        // ========================================================================

        // Payload data width
        localparam int DATA_W = 32;

        // Registered FIFO entries
        localparam int FIFO_DEPTH = 16;

        // Skid buffer entries behind the latency bridge
        localparam int SKID_DEPTH = 4;

        // FIFO level, 0 to FIFO_DEPTH
        localparam int LEVEL_W = 5;

        // Bridge occupancy, one beat in flight plus the skid entries
        localparam int OCC_W = 3;

        // Total beats held, FIFO plus bridge, at most 20
        localparam int AVAIL_W = 6;

        // Delivery counters, free running and wrapping
        localparam int CNT_W = 16;

        // ========================================================================
        // Beat type
        // ========================================================================

        // One stream beat, data word plus end of packet marker
        typedef struct packed {
                logic [DATA_W-1:0] data;
                logic              last;
        } beat_t;

endpackage : stream_pkg

//--- run_sim.sh
#!/bin/sh
# Build and run the stream channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_stream_channel -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_stream_channel)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- sim/tb_stream_channel.sv
/*
 * Directed testbench for the stream staging channel. Each test is a task
 * that drives the top level, and a queue scoreboard checks every delivered
 * beat against the accepted ones. A watchdog bounds the run.
 */

module tb_stream_channel
        import stream_pkg::*;
;

        localparam int CLK_PERIOD    = 20;
        // Beats offered by the latency, back-pressure, random and enable tests
        localparam int PLANNED_BEATS = 4 + 30 + 300 + 10;
        localparam int WATCHDOG_TIME = 20 * PLANNED_BEATS * CLK_PERIOD + 2000;

        logic               clk;
        logic               rst_n;
        logic               enable;
        logic               in_valid;
        logic               in_ready;
        logic [DATA_W-1:0]  in_data;
        logic               in_last;
        logic               out_valid;
        logic               out_ready;
        logic [DATA_W-1:0]  out_data;
        logic               out_last;
        logic [AVAIL_W-1:0] avail_count;
        logic [CNT_W-1:0]   beats_out;
        logic [CNT_W-1:0]   pkts_out;
        logic               idle;

        // Scoreboard of {data, last} for each accepted beat
        logic [DATA_W:0]    exp_q [$];
        logic [DATA_W:0]    exp_beat;
        integer             seed;
        int                 cycle;
        int                 acc_cycle;
        int                 acc_total;
        int                 del_total;
        int                 last_total;
        int                 pass_cnt;
        int                 fail_cnt;

        stream_channel_top DUT (
                .clk         (clk),
                .rst_n       (rst_n),
                .enable      (enable),
                .in_valid    (in_valid),
                .in_ready    (in_ready),
                .in_data     (in_data),
                .in_last     (in_last),
                .out_valid   (out_valid),
                .out_ready   (out_ready),
                .out_data    (out_data),
                .out_last    (out_last),
                .avail_count (avail_count),
                .beats_out   (beats_out),
                .pkts_out    (pkts_out),
                .idle        (idle)
        );

        // ========================================================================
        // Clock, cycle count, watchdog
        // ========================================================================

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        always @(posedge clk) begin
                cycle <= cycle + 1;
        end

        initial begin
                #(WATCHDOG_TIME);
                $display("Watchdog expired after %0d time units, run stopped", WATCHDOG_TIME);
                $display("CHECKS FAILED");
                $finish;
        end

        // ========================================================================
        // Helpers
        // ========================================================================

        task automatic report_mismatch(input string msg);
                $display("MISMATCH at %0t: %s", $time, msg);
                fail_cnt++;
        endtask

        task automatic report_failure(input string msg);
                $display("FAILURE at %0t: %s", $time, msg);
                fail_cnt++;
        endtask

        // Inputs change a small delay after the rising edge
        task automatic step_cycle();
                @(posedge clk);
                #2;
        endtask

        task automatic load_random_beat();
                logic [31:0] rnd;
                rnd     = $random(seed);
                in_data = $random(seed);
                in_last = (rnd[1:0] == 2'b00);
        endtask

        task automatic wait_for_drain(input int max_cycles);
                int n;
                n = 0;
                while ((exp_q.size() != 0 || avail_count != '0) && n < max_cycles) begin
                        @(negedge clk);
                        n++;
                end
                if (n >= max_cycles) begin
                        report_failure("channel did not drain in time");
                end
                // Let idle and the counters settle
                repeat (2) @(negedge clk);
                step_cycle();
        endtask

        task automatic print_test_result(input string name, input int errs_at_start);
                $display("[%s] finished with %0d errors", name, fail_cnt - errs_at_start);
        endtask

        // ========================================================================
        // Scoreboard monitor
        // ========================================================================

        // Negedge sampling sees the values that decide the next rising edge
        always @(negedge clk) begin
                if (rst_n) begin
                        if (out_valid && out_ready) begin
                                if (exp_q.size() == 0) begin
                                        report_failure("beat delivered with none outstanding");
                                end else begin
                                        exp_beat = exp_q.pop_front();
                                        if ({out_data, out_last} !== exp_beat) begin
                                                report_mismatch($sformatf(
                                                        "got %h/%b, expected %h/%b", out_data,
                                                        out_last, exp_beat[DATA_W:1], exp_beat[0]));
                                        end else begin
                                                pass_cnt++;
                                        end
                                        del_total++;
                                        if (exp_beat[0]) begin
                                                last_total++;
                                        end
                                end
                        end
                        if (in_valid && in_ready) begin
                                exp_q.push_back({in_data, in_last});
                                acc_total++;
                                acc_cycle = cycle;
                        end
                end
        end

        // ========================================================================
        // Tests
        // ========================================================================

        task automatic check_reset_state();
                @(negedge clk);
                if (out_valid || !in_ready || avail_count != '0) begin
                        report_mismatch("stream status wrong after reset");
                end else begin
                        pass_cnt++;
                end
                if (beats_out != '0 || pkts_out != '0 || !idle) begin
                        report_mismatch("counters or idle wrong after reset");
                end else begin
                        pass_cnt++;
                end
                step_cycle();
        endtask

        task automatic latency_order_test();
                int errs;
                int k;
                int n;
                int seen_cycle;
                bit got;
                errs      = fail_cnt;
                enable    = 1'b1;
                out_ready = 1'b1;
                for (k = 0; k < 4; k++) begin
                        load_random_beat();
                        in_valid = 1'b1;
                        step_cycle();
                        in_valid = 1'b0;
                        got        = 1'b0;
                        seen_cycle = 0;
                        for (n = 0; n < 10 && !got; n++) begin
                                @(negedge clk);
                                if (out_valid) begin
                                        got        = 1'b1;
                                        seen_cycle = cycle;
                                end
                        end
                        if (!got) begin
                                report_failure("out_valid never rose after a single beat");
                        end else if (seen_cycle - acc_cycle != 3) begin
                                report_mismatch($sformatf("latency %0d cycles, expected 3",
                                        seen_cycle - acc_cycle));
                        end else begin
                                pass_cnt++;
                        end
                        wait_for_drain(20);
                end
                print_test_result("latency_order", errs);
        endtask

        task automatic backpressure_test();
                int errs;
                int k;
                int accepted;
                bit took;
                errs      = fail_cnt;
                accepted  = 0;
                out_ready = 1'b0;
                in_valid  = 1'b1;
                load_random_beat();
                for (k = 0; k < 30; k++) begin
                        @(negedge clk);
                        took = in_ready;
                        if (accepted >= 20 && in_ready) begin
                                report_mismatch("in_ready high with 20 beats held");
                        end
                        step_cycle();
                        if (took) begin
                                accepted++;
                                load_random_beat();
                        end
                end
                in_valid = 1'b0;
                if (accepted != 20) begin
                        report_mismatch($sformatf("%0d beats accepted, expected 20", accepted));
                end else begin
                        pass_cnt++;
                end
                @(negedge clk);
                if (avail_count != 6'd20 || in_ready) begin
                        report_mismatch($sformatf("avail_count %0d, in_ready %b when full",
                                avail_count, in_ready));
                end else begin
                        pass_cnt++;
                end
                step_cycle();
                out_ready = 1'b1;
                wait_for_drain(100);
                print_test_result("backpressure", errs);
        endtask

        task automatic random_traffic_test();
                int errs;
                int k;
                int acc_start;
                int del_start;
                logic [31:0] rnd;
                errs      = fail_cnt;
                acc_start = acc_total;
                del_start = del_total;
                for (k = 0; k < 300; k++) begin
                        rnd       = $random(seed);
                        in_valid  = rnd[0];
                        out_ready = rnd[4];
                        load_random_beat();
                        step_cycle();
                end
                in_valid  = 1'b0;
                out_ready = 1'b1;
                wait_for_drain(100);
                if (acc_total - acc_start != del_total - del_start) begin
                        report_mismatch($sformatf("%0d beats accepted, %0d delivered",
                                acc_total - acc_start, del_total - del_start));
                end else begin
                        pass_cnt++;
                end
                print_test_result("random_traffic", errs);
        endtask

        task automatic enable_gating_test();
                int errs;
                int k;
                int del_start;
                errs      = fail_cnt;
                del_start = del_total;
                enable    = 1'b0;
                out_ready = 1'b1;
                // drain_en follows enable one cycle later
                step_cycle();
                step_cycle();
                for (k = 0; k < 10; k++) begin
                        load_random_beat();
                        in_valid = 1'b1;
                        @(negedge clk);
                        if (!in_ready) begin
                                report_mismatch("in_ready low while filling a gated channel");
                        end
                        if (out_valid) begin
                                report_mismatch("out_valid high while draining is disabled");
                        end
                        step_cycle();
                end
                in_valid = 1'b0;
                repeat (3) @(negedge clk);
                if (avail_count != 6'd10 || out_valid || idle) begin
                        report_mismatch($sformatf("avail_count %0d, out_valid %b, idle %b gated",
                                avail_count, out_valid, idle));
                end else begin
                        pass_cnt++;
                end
                step_cycle();
                enable = 1'b1;
                wait_for_drain(100);
                if (del_total - del_start != 10) begin
                        report_mismatch($sformatf("%0d beats delivered after enable, expected 10",
                                del_total - del_start));
                end else begin
                        pass_cnt++;
                end
                print_test_result("enable_gating", errs);
        endtask

        task automatic counters_idle_test();
                int errs;
                errs = fail_cnt;
                @(negedge clk);
                if (beats_out != CNT_W'(del_total) || pkts_out != CNT_W'(last_total)) begin
                        report_mismatch($sformatf("beats_out %0d pkts_out %0d, expected %0d %0d",
                                beats_out, pkts_out, CNT_W'(del_total), CNT_W'(last_total)));
                end else begin
                        pass_cnt++;
                end
                if (!idle || avail_count != '0) begin
                        report_mismatch("channel not idle after draining");
                end else begin
                        pass_cnt++;
                end
                step_cycle();
                print_test_result("counters_idle", errs);
        endtask

        // ========================================================================
        // Main sequence
        // ========================================================================

        initial begin
                seed       = 32'ha1fcb8a2;
                acc_cycle  = 0;
                acc_total  = 0;
                del_total  = 0;
                last_total = 0;
                pass_cnt   = 0;
                fail_cnt   = 0;
                rst_n      = 1'b0;
                enable     = 1'b1;
                in_valid   = 1'b0;
                in_data    = '0;
                in_last    = 1'b0;
                out_ready  = 1'b0;

                repeat (2) @(posedge clk);
                #2;
                rst_n = 1'b1;

                check_reset_state();
                latency_order_test();
                backpressure_test();
                random_traffic_test();
                enable_gating_test();
                counters_idle_test();

                $display("Summary: %0d checks passed, %0d errors", pass_cnt, fail_cnt);
                if (fail_cnt == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule : tb_stream_channel

//--- src/stream_channel_ctrl.sv
/*
 * Channel control and status. Registers the enable level into the
 * drain gate, totals the beats held, counts delivered beats and
 * packets, and flags an empty channel.
 */

module stream_channel_ctrl
        import stream_pkg::*;
(
        input  logic               clk,
        input  logic               rst_n,
        input  logic               enable,
        fifo_rd_if.mon             rd,
        input  logic [OCC_W-1:0]   occupancy,
        input  logic               out_fire,
        input  logic               out_last,
        output logic               drain_en,
        output logic [AVAIL_W-1:0] avail_count,
        output logic [CNT_W-1:0]   beats_out,
        output logic [CNT_W-1:0]   pkts_out,
        output logic               idle
);

        // ========================================================================
        // Occupancy total
        // ========================================================================

        // Both terms come from flops and move on the same edges,
        // so the sum is exact after every handshake
        assign avail_count = AVAIL_W'(rd.level) + AVAIL_W'(occupancy);

        // ========================================================================
        // Drain gate, counters and idle
        // ========================================================================

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        drain_en  <= 1'b0;
                        beats_out <= '0;
                        pkts_out  <= '0;
                        idle      <= 1'b1;
                end else begin
                        // One cycle from enable to the bridge
                        drain_en <= enable;

                        // Counters wrap at 2^CNT_W
                        if (out_fire) begin
                                beats_out <= beats_out + CNT_W'(1);
                                // Packet ends on the beat with last set
                                if (out_last) begin
                                        pkts_out <= pkts_out + CNT_W'(1);
                                end
                        end

                        idle <= (avail_count == '0);
                end
        end

endmodule : stream_channel_ctrl

//--- src/stream_channel_top.sv
/*
 * Top level of the single-channel stream staging path.
 * Producer beats go through the registered FIFO and the latency bridge
 * to the consumer. Plain valid/ready ports, status from the control block.
 */

module stream_channel_top
        import stream_pkg::*;
(
        input  logic               clk,
        input  logic               rst_n,
        input  logic               enable,
        input  logic               in_valid,
        output logic               in_ready,
        input  logic [DATA_W-1:0]  in_data,
        input  logic               in_last,
        output logic               out_valid,
        input  logic               out_ready,
        output logic [DATA_W-1:0]  out_data,
        output logic               out_last,
        output logic [AVAIL_W-1:0] avail_count,
        output logic [CNT_W-1:0]   beats_out,
        output logic [CNT_W-1:0]   pkts_out,
        output logic               idle
);

        beat_t            in_beat;
        beat_t            out_beat;
        logic             drain_en;
        logic             out_fire;
        logic [OCC_W-1:0] occupancy;

        fifo_rd_if rd_bus ();

        // Pack and unpack the beat at the ports
        assign in_beat.data = in_data;
        assign in_beat.last = in_last;
        assign out_data     = out_beat.data;
        assign out_last     = out_beat.last;
        assign out_fire     = out_valid && out_ready;

        stream_reg_fifo #(
                .DEPTH       (FIFO_DEPTH)
        ) u_fifo (
                .clk         (clk),
                .rst_n       (rst_n),
                .wr_valid    (in_valid),
                .wr_ready    (in_ready),
                .wr_data     (in_beat),
                .rd          (rd_bus.fifo)
        );

        stream_latency_bridge u_bridge (
                .clk         (clk),
                .rst_n       (rst_n),
                .rd          (rd_bus.bridge),
                .drain_en    (drain_en),
                .m_valid     (out_valid),
                .m_ready     (out_ready),
                .m_data      (out_beat),
                .occupancy   (occupancy)
        );

        stream_channel_ctrl u_ctrl (
                .clk         (clk),
                .rst_n       (rst_n),
                .enable      (enable),
                .rd          (rd_bus.mon),
                .occupancy   (occupancy),
                .out_fire    (out_fire),
                .out_last    (out_last),
                .drain_en    (drain_en),
                .avail_count (avail_count),
                .beats_out   (beats_out),
                .pkts_out    (pkts_out),
                .idle        (idle)
        );

endmodule : stream_channel_top

//--- stream/stream_latency_bridge.sv
/*
 * Turns the latency-1 read of the registered FIFO into a valid/ready
 * stream. A slot in the skid buffer is reserved at pop time, the beat
 * lands in the skid buffer one cycle later, and the consumer drains it.
 */

module stream_latency_bridge
        import stream_pkg::*;
(
        input  logic             clk,
        input  logic             rst_n,
        fifo_rd_if.bridge        rd,
        input  logic             drain_en,
        output logic             m_valid,
        input  logic             m_ready,
        output beat_t            m_data,
        output logic [OCC_W-1:0] occupancy
);

        // Beat popped last cycle, its data is on rd.data now
        logic             drain_ip;
        logic [OCC_W-1:0] skid_count;
        logic             m_fire;
        logic             room;

        // ========================================================================
        // Pop decision
        // ========================================================================

        assign m_fire = m_valid && m_ready;

        // In-flight beat holds a reserved slot, so the skid write never stalls
        assign occupancy = skid_count + OCC_W'(drain_ip);
        assign room      = (occupancy < OCC_W'(SKID_DEPTH));

        // A beat leaving this cycle frees the slot the next pop needs
        assign rd.pop = rd.avail && drain_en && (room || m_fire);

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        drain_ip <= 1'b0;
                end else begin
                        drain_ip <= rd.pop;
                end
        end

        // ========================================================================
        // Skid buffer
        // ========================================================================

        // Write side ready is always high when drain_ip is set
        stream_skid_fifo #(
                .DEPTH    (SKID_DEPTH)
        ) u_skid (
                .clk      (clk),
                .rst_n    (rst_n),
                .wr_valid (drain_ip),
                .wr_ready (),
                .wr_data  (rd.data),
                .rd_valid (m_valid),
                .rd_ready (m_ready),
                .rd_data  (m_data),
                .count    (skid_count)
        );

endmodule : stream_latency_bridge

//--- stream/stream_reg_fifo.sv
/*
 * Synchronous circular FIFO with a registered read port.
 * A pop loads the output register, so data is valid one cycle later
 * and holds until the next pop. Level and avail come from flops.
 */

module stream_reg_fifo
        import stream_pkg::*;
#(
        parameter int DEPTH = FIFO_DEPTH
) (
        input  logic    clk,
        input  logic    rst_n,
        input  logic    wr_valid,
        output logic    wr_ready,
        input  beat_t   wr_data,
        fifo_rd_if.fifo rd
);

        localparam int PTR_W = $clog2(DEPTH);

        beat_t              mem [DEPTH];
        logic [PTR_W-1:0]   wr_ptr;
        logic [PTR_W-1:0]   rd_ptr;
        logic [LEVEL_W-1:0] level;
        logic               wr_fire;
        logic               rd_fire;

        // ========================================================================
        // Handshakes and status
        // ========================================================================

        // Room while below full, a same cycle pop does not make room
        assign wr_ready = (level < LEVEL_W'(DEPTH));
        assign wr_fire  = wr_valid && wr_ready;

        // Pop is qualified again so a stray request cannot underflow
        assign rd_fire  = rd.pop && rd.avail;

        assign rd.level = level;
        assign rd.avail = (level != '0);

        // ========================================================================
        // Pointers and level
        // ========================================================================

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        level  <= '0;
                end else begin
                        if (wr_fire) begin
                                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (rd_fire) begin
                                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        // Simultaneous write and pop leave the level unchanged
                        case ({wr_fire, rd_fire})
                                2'b10:   level <= level + 1'b1;
                                2'b01:   level <= level - 1'b1;
                                default: level <= level;
                        endcase
                end
        end

        // ========================================================================
        // Storage and read register
        // ========================================================================

        always_ff @(posedge clk) begin
                if (wr_fire) begin
                        mem[wr_ptr] <= wr_data;
                end
                // One cycle read latency
                if (rd_fire) begin
                        rd.data <= mem[rd_ptr];
                end
        end

endmodule : stream_reg_fifo

//--- stream/stream_skid_fifo.sv
/*
 * Small show-ahead FIFO used as the skid buffer of the latency bridge.
 * The head entry drives rd_data straight from storage. A write and a
 * read may complete in the same cycle. count is registered.
 */

module stream_skid_fifo
        import stream_pkg::*;
#(
        parameter int DEPTH = SKID_DEPTH
) (
        input  logic             clk,
        input  logic             rst_n,
        input  logic             wr_valid,
        output logic             wr_ready,
        input  beat_t            wr_data,
        output logic             rd_valid,
        input  logic             rd_ready,
        output beat_t            rd_data,
        output logic [OCC_W-1:0] count
);

        localparam int PTR_W = $clog2(DEPTH);

        beat_t            mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic             wr_fire;
        logic             rd_fire;

        // Full blocks writes even when the head leaves this cycle
        assign wr_ready = (count < OCC_W'(DEPTH));
        assign rd_valid = (count != '0);
        assign wr_fire  = wr_valid && wr_ready;
        assign rd_fire  = rd_valid && rd_ready;

        // Show-ahead head entry
        assign rd_data  = mem[rd_ptr];

        // ========================================================================
        // Pointers and count
        // ========================================================================

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wr_fire) begin
                                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (rd_fire) begin
                                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        case ({wr_fire, rd_fire})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // Entry written here is visible at the head next cycle
        always_ff @(posedge clk) begin
                if (wr_fire) begin
                        mem[wr_ptr] <= wr_data;
                end
        end

endmodule : stream_skid_fifo

//--- vlog.f
common/stream_pkg.sv
common/fifo_rd_if.sv
stream/stream_reg_fifo.sv
stream/stream_skid_fifo.sv
stream/stream_latency_bridge.sv
src/stream_channel_ctrl.sv
src/stream_channel_top.sv
sim/tb_stream_channel.sv
